//--- asg_chan.f
src/asg_pkg.sv
src/asg_regs.sv
src/asg_table.sv
src/asg_ptr_gen.sv
src/asg_out_stage.sv
src/asg_chan.sv
bench/asg_chan_sva.sv
bench/asg_chan_tb.sv

//--- bench/asg_chan_sva.sv
//////////////////////////////////////////////////
// asg channel stream and handshake assertions
// bound into the channel top
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_chan_sva (
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic           req,
  input  logic           ack,
  input  asg_pkg::smp_t  smp,
  input  logic           vld,
  input  logic           lst,
  input  logic           rdy
);

  // output beat held until taken
  property stall_hold;
    @(posedge sto) disable iff (ctl_rst)
      vld && !rdy |=> vld && $stable(smp) && $stable(lst);
  endproperty

  hold_chk: assert property (stall_hold)
    else $error("stream beat changed while stalled");

  // ack only answers a pending req
  ack_chk: assert property (@(posedge sto) disable iff (ctl_rst) $rose(ack) |-> req)
    else $error("ack rose with req low");

  rst_chk: assert property (@(posedge sto) ctl_rst |=> !vld)
    else $error("vld high after reset");

endmodule

bind asg_chan asg_chan_sva asg_chan_sva_inst (
  .sto     (sto),
  .ctl_rst (ctl_rst),
  .req     (req),
  .ack     (ack),
  .smp     (smp),
  .vld     (vld),
  .lst     (lst),
  .rdy     (rdy)
);

`default_nettype wire

//--- bench/asg_chan_tb.sv
//////////////////////////////////////////////////
// asg channel testbench
// host accesses, random periodic and burst runs,
// back-pressure and a reference beat model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_chan_tb;

  localparam int HOST_TMO = 100;
  localparam int RUN_TMO  = 20000;

  logic                     sto;
  logic                     ctl_rst;
  logic                     req;
  logic                     we;
  logic [asg_pkg::AW-1:0]   addr;
  logic [asg_pkg::HW-1:0]   wdata;
  logic                     ack;
  logic [asg_pkg::HW-1:0]   rdata;
  logic                     trg;
  asg_pkg::smp_t            smp;
  logic                     vld;
  logic                     lst;
  logic                     rdy;
  logic                     evn_per;
  logic                     evn_lst;

  int                       seed = 93;
  logic                     bp_on;
  logic                     chk_en;
  int                       per_cnt;
  int                       lst_cnt;
  // table mirror and expected {lst, smp} beats
  asg_pkg::smp_t            tbl [0:(1 << asg_pkg::CWM)-1];
  logic [asg_pkg::DW:0]     exp_q [$];
  logic [asg_pkg::DW:0]     exp_beat;

  asg_chan asg_chan_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .req     (req),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .ack     (ack),
    .rdata   (rdata),
    .trg     (trg),
    .smp     (smp),
    .vld     (vld),
    .lst     (lst),
    .rdy     (rdy),
    .evn_per (evn_per),
    .evn_lst (evn_lst)
  );

  initial begin
    sto = 1'b0;
    forever #10 sto = ~sto;
  end

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    abort_run($sformatf("** Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                        $time, sig, exp, got));
  endtask

  //////////////////////////////////////////////////
  // host port, four-phase
  //////////////////////////////////////////////////

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack !== level) begin
      @(posedge sto);
      n++;
      if (n > HOST_TMO) abort_run("host handshake timed out waiting for ack");
    end
  endtask

  task automatic host_write(input logic [asg_pkg::AW-1:0] a, input logic [31:0] d);
    @(posedge sto);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= a;
    wdata <= d;
    wait_ack(1'b1);
    req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic host_read(input logic [asg_pkg::AW-1:0] a, output logic [31:0] d);
    @(posedge sto);
    req  <= 1'b1;
    we   <= 1'b0;
    addr <= a;
    wait_ack(1'b1);
    // data valid with ack
    d   = rdata;
    req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic check_reg(input logic [asg_pkg::AW-2:0] r, input logic [31:0] mask);
    logic [31:0] d;
    logic [31:0] got;
    d = $random(seed);
    host_write({1'b0, r}, d);
    host_read({1'b0, r}, got);
    assert (got == (d & mask)) else report_mismatch("rdata", d & mask, got);
  endtask

  task automatic fill_table();
    logic [31:0] d;
    logic [31:0] got;
    for (int i = 0; i < (1 << asg_pkg::CWM); i++) begin
      d = $random(seed);
      host_write({1'b1, 9'(i)}, d);
      tbl[i] = d[asg_pkg::DW-1:0];
    end
    for (int i = 0; i < (1 << asg_pkg::CWM); i++) begin
      host_read({1'b1, 9'(i)}, got);
      assert (got == {18'd0, tbl[i]}) else report_mismatch("rdata", {18'd0, tbl[i]}, got);
    end
  endtask

  task automatic pulse_trg();
    @(posedge sto);
    trg <= 1'b1;
    @(posedge sto);
    trg <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // waits on the stream
  //////////////////////////////////////////////////

  task automatic wait_backlog(input int left);
    int n;
    n = 0;
    while (exp_q.size() > left) begin
      @(posedge sto);
      n++;
      if (n > RUN_TMO) abort_run("timed out waiting for stream beats");
    end
  endtask

  task automatic wait_idle();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 8) begin
      @(posedge sto);
      n++;
      quiet = vld ? 0 : quiet + 1;
      if (n > RUN_TMO) abort_run("stream never went idle");
    end
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!vld) begin
      @(posedge sto);
      n++;
      if (n > HOST_TMO) abort_run("no stream beat after run command");
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // pointer steps by ste+1, wraps by siz+1
  task automatic build_periodic(input int siz, input int ste, input int off, input int n);
    int ptr;
    int nxt;
    exp_q.delete();
    ptr = off;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back({1'b0, tbl[ptr >> asg_pkg::CWF]});
      nxt = ptr + ste + 1;
      if (nxt >= siz + 1) nxt = nxt - siz - 1;
      ptr = nxt & ((1 << asg_pkg::PW) - 1);
    end
  endtask

  // each entry bdr+1 times, then hold entry bdl to period end
  task automatic build_burst(input int bdr, input int bdl, input int bpl, input int bpn);
    int idx;
    exp_q.delete();
    for (int p = 0; p <= bpn; p++) begin
      for (int k = 0; k <= bpl; k++) begin
        idx = k / (bdr + 1);
        if (idx > bdl) idx = bdl;
        exp_q.push_back({(p == bpn) && (k == bpl), tbl[idx]});
      end
    end
  endtask

  // random ready when back-pressure is on
  always @(posedge sto) begin
    if (bp_on) rdy <= ($random(seed) & 3) != 0;
    else rdy <= 1'b1;
  end

  // in-order beat compare and event counts
  always @(posedge sto) begin
    if (!ctl_rst && chk_en) begin
      if (vld && rdy) begin
        assert (exp_q.size() != 0) else abort_run("stream beat arrived with none expected");
        exp_beat = exp_q.pop_front();
        assert (smp == exp_beat[asg_pkg::DW-1:0])
          else report_mismatch("smp", exp_beat[asg_pkg::DW-1:0], smp);
        assert (lst == exp_beat[asg_pkg::DW])
          else report_mismatch("lst", exp_beat[asg_pkg::DW], lst);
      end
      if (evn_per) per_cnt++;
      if (evn_lst) lst_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // test runs
  //////////////////////////////////////////////////

  task automatic run_periodic();
    int siz;
    int ste;
    int off;
    logic [31:0] got;
    siz = 16'h4000 | ($random(seed) & 16'hBFFF);
    ste = $random(seed) & 16'h0FFF;
    off = $random(seed) & 16'h3FFF;
    host_write({1'b0, asg_pkg::REG_MODE}, 0);
    host_write({1'b0, asg_pkg::REG_SIZ}, siz);
    host_write({1'b0, asg_pkg::REG_STE}, ste);
    host_write({1'b0, asg_pkg::REG_OFF}, off);
    build_periodic(siz, ste, off, 400);
    bp_on = 1'b1;
    // start and trigger together
    host_write({1'b0, asg_pkg::REG_CTL}, 5);
    wait_backlog(340);
    // retrigger mid-run, sequence must carry on
    host_write({1'b0, asg_pkg::REG_CTL}, 4);
    pulse_trg();
    wait_backlog(250);
    host_write({1'b0, asg_pkg::REG_CTL}, 2);
    wait_idle();
    exp_q.delete();
    host_read({1'b0, asg_pkg::REG_STS}, got);
    assert (got == 0) else report_mismatch("sts", 0, got);
  endtask

  task automatic run_burst(input logic bp);
    int bdr;
    int bdl;
    int bpl;
    int bpn;
    logic [31:0] got;
    bdr = $random(seed) & 3;
    bdl = $random(seed) & 15;
    bpl = $random(seed) & 63;
    bpn = $random(seed) & 3;
    bp_on = bp;
    host_write({1'b0, asg_pkg::REG_MODE}, 1);
    host_write({1'b0, asg_pkg::REG_BDR}, bdr);
    host_write({1'b0, asg_pkg::REG_BDL}, bdl);
    host_write({1'b0, asg_pkg::REG_BPL}, bpl);
    host_write({1'b0, asg_pkg::REG_BPN}, bpn);
    build_burst(bdr, bdl, bpl, bpn);
    per_cnt = 0;
    lst_cnt = 0;
    host_write({1'b0, asg_pkg::REG_CTL}, 1);
    pulse_trg();
    wait_backlog(0);
    wait_idle();
    assert (per_cnt == bpn + 1) else report_mismatch("evn_per count", bpn + 1, per_cnt);
    assert (lst_cnt == 1) else report_mismatch("evn_lst count", 1, lst_cnt);
    host_read({1'b0, asg_pkg::REG_CBPL}, got);
    assert (got == bpl) else report_mismatch("sts_bpl", bpl, got);
    host_read({1'b0, asg_pkg::REG_CBPN}, got);
    assert (got == bpn) else report_mismatch("sts_bpn", bpn, got);
    // still started, run finished
    host_read({1'b0, asg_pkg::REG_STS}, got);
    assert (got == 1) else report_mismatch("sts", 1, got);
    host_write({1'b0, asg_pkg::REG_CTL}, 2);
  endtask

  task automatic run_reset();
    logic [31:0] got;
    chk_en = 1'b0;
    bp_on  = 1'b0;
    // endless burst, cut by reset
    host_write({1'b0, asg_pkg::REG_MODE}, 3);
    host_write({1'b0, asg_pkg::REG_CTL}, 5);
    wait_valid();
    @(posedge sto);
    ctl_rst <= 1'b1;
    repeat (4) @(posedge sto);
    ctl_rst <= 1'b0;
    @(posedge sto);
    assert (vld == 1'b0) else report_mismatch("vld", 0, vld);
    wait_idle();
    host_read({1'b0, asg_pkg::REG_STS}, got);
    assert (got == 0) else report_mismatch("sts", 0, got);
  endtask

  initial begin
    ctl_rst = 1'b1;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    trg     = 1'b0;
    rdy     = 1'b0;
    bp_on   = 1'b0;
    chk_en  = 1'b1;
    per_cnt = 0;
    lst_cnt = 0;
    repeat (4) @(posedge sto);
    ctl_rst <= 1'b0;

    // register readback, zero-extended
    check_reg(asg_pkg::REG_MODE, 32'h3);
    check_reg(asg_pkg::REG_SIZ, 32'hFFFF);
    check_reg(asg_pkg::REG_STE, 32'hFFFF);
    check_reg(asg_pkg::REG_OFF, 32'hFFFF);
    check_reg(asg_pkg::REG_BDR, 32'hFF);
    check_reg(asg_pkg::REG_BDL, 32'hFF);
    check_reg(asg_pkg::REG_BPL, 32'hFFFF);
    check_reg(asg_pkg::REG_BPN, 32'hFF);
    fill_table();

    run_periodic();

    // trigger while stopped gives nothing
    bp_on = 1'b0;
    pulse_trg();
    host_write({1'b0, asg_pkg::REG_CTL}, 4);
    wait_idle();

    run_burst(1'b0);
    run_burst(1'b1);
    run_reset();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/asg_chan.sv
//////////////////////////////////////////////////
// asg channel top
// register block, pointer engine, sample table
// and output stage of one generator channel
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_chan (
  input  logic                     sto,
  input  logic                     ctl_rst,
  // host port
  input  logic                     req,
  input  logic                     we,
  input  logic [asg_pkg::AW-1:0]   addr,
  input  logic [asg_pkg::HW-1:0]   wdata,
  output logic                     ack,
  output logic [asg_pkg::HW-1:0]   rdata,
  // external trigger
  input  logic                     trg,
  // sample stream
  output asg_pkg::smp_t            smp,
  output logic                     vld,
  output logic                     lst,
  input  logic                     rdy,
  // events
  output logic                     evn_per,
  output logic                     evn_lst
);

  logic                     tbl_we;
  logic [asg_pkg::CWM-1:0]  tbl_waddr;
  asg_pkg::smp_t            tbl_wdata;
  asg_pkg::smp_t            tbl_hdata;
  asg_pkg::smp_t            tbl_rdata;
  logic                     cmd_str;
  logic                     cmd_stp;
  logic                     cmd_trg;
  logic                     cfg_ben;
  logic                     cfg_inf;
  logic [asg_pkg::PW-1:0]   cfg_siz;
  logic [asg_pkg::PW-1:0]   cfg_ste;
  logic [asg_pkg::PW-1:0]   cfg_off;
  logic [asg_pkg::CWR-1:0]  cfg_bdr;
  logic [asg_pkg::CWM-1:0]  cfg_bdl;
  logic [asg_pkg::CWL-1:0]  cfg_bpl;
  logic [asg_pkg::CWN-1:0]  cfg_bpn;
  logic                     sts_str;
  logic                     sts_trg;
  logic [asg_pkg::CWL-1:0]  sts_bpl;
  logic [asg_pkg::CWN-1:0]  sts_bpn;
  logic [asg_pkg::CWM-1:0]  raddr;
  logic                     ren;
  logic                     tag_vld;
  logic                     tag_lst;
  logic                     adv;

  asg_regs asg_regs_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .tbl_we    (tbl_we),
    .tbl_waddr (tbl_waddr),
    .tbl_wdata (tbl_wdata),
    .cmd_str   (cmd_str),
    .cmd_stp   (cmd_stp),
    .cmd_trg   (cmd_trg),
    .cfg_ben   (cfg_ben),
    .cfg_inf   (cfg_inf),
    .cfg_siz   (cfg_siz),
    .cfg_ste   (cfg_ste),
    .cfg_off   (cfg_off),
    .cfg_bdr   (cfg_bdr),
    .cfg_bdl   (cfg_bdl),
    .cfg_bpl   (cfg_bpl),
    .cfg_bpn   (cfg_bpn),
    .sts_str   (sts_str),
    .sts_trg   (sts_trg),
    .sts_bpl   (sts_bpl),
    .sts_bpn   (sts_bpn),
    .tbl_rdata (tbl_hdata)
  );

  asg_ptr_gen asg_ptr_gen_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .cmd_str (cmd_str),
    .cmd_stp (cmd_stp),
    .cmd_trg (cmd_trg),
    .trg     (trg),
    .adv     (adv),
    .cfg_ben (cfg_ben),
    .cfg_inf (cfg_inf),
    .cfg_siz (cfg_siz),
    .cfg_ste (cfg_ste),
    .cfg_off (cfg_off),
    .cfg_bdr (cfg_bdr),
    .cfg_bdl (cfg_bdl),
    .cfg_bpl (cfg_bpl),
    .cfg_bpn (cfg_bpn),
    .sts_str (sts_str),
    .sts_trg (sts_trg),
    .sts_bpl (sts_bpl),
    .sts_bpn (sts_bpn),
    .raddr   (raddr),
    .ren     (ren),
    .tag_vld (tag_vld),
    .tag_lst (tag_lst),
    .evn_per (evn_per)
  );

  // host read index taken straight from the held address
  asg_table asg_table_inst (
    .sto   (sto),
    .we    (tbl_we),
    .waddr (tbl_waddr),
    .wdata (tbl_wdata),
    .haddr (addr[asg_pkg::CWM-1:0]),
    .ren   (ren),
    .raddr (raddr),
    .adv   (adv),
    .hdata (tbl_hdata),
    .rdata (tbl_rdata)
  );

  asg_out_stage asg_out_stage_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .tag_vld (tag_vld),
    .tag_lst (tag_lst),
    .rdata   (tbl_rdata),
    .rdy     (rdy),
    .adv     (adv),
    .smp     (smp),
    .vld     (vld),
    .lst     (lst),
    .evn_lst (evn_lst)
  );

endmodule

`default_nettype wire

//--- src/asg_out_stage.sv
//////////////////////////////////////////////////
// asg output stage
// tag alignment, output register, valid/ready
// back-pressure and last event
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_out_stage (
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic           tag_vld,
  input  logic           tag_lst,
  input  asg_pkg::smp_t  rdata,
  input  logic           rdy,
  output logic           adv,
  output asg_pkg::smp_t  smp,
  output logic           vld,
  output logic           lst,
  output logic           evn_lst
);

  // tags lined up with table read data
  logic vld_d;
  logic lst_d;

  // move when the output is taken or empty
  assign adv = rdy | ~vld;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_d   <= 1'b0;
      lst_d   <= 1'b0;
      smp     <= '0;
      vld     <= 1'b0;
      lst     <= 1'b0;
      evn_lst <= 1'b0;
    end else begin
      // pulse with the last beat entering the output
      evn_lst <= adv & vld_d & lst_d;
      if (adv) begin
        vld_d <= tag_vld;
        lst_d <= tag_lst;
        smp   <= rdata;
        vld   <= vld_d;
        lst   <= vld_d & lst_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/asg_pkg.sv
//////////////////////////////////////////////////
// asg shared definitions
// pointer and counter widths, sample type and the
// host register map of one generator channel
//////////////////////////////////////////////////
`default_nettype none

package asg_pkg;

  // table pointer, integer and fraction part
  localparam int CWM = 8;
  localparam int CWF = 8;
  localparam int PW  = CWM + CWF;

  // burst counters
  localparam int CWR = 8;
  localparam int CWL = 16;
  localparam int CWN = 8;

  // sample, host address and host data
  localparam int DW = 14;
  localparam int AW = 10;
  localparam int HW = 32;

  typedef logic [DW-1:0] smp_t;

  // register map, top address bit clear
  localparam logic [AW-2:0] REG_CTL  = 'd0;
  localparam logic [AW-2:0] REG_MODE = 'd1;
  localparam logic [AW-2:0] REG_SIZ  = 'd2;
  localparam logic [AW-2:0] REG_STE  = 'd3;
  localparam logic [AW-2:0] REG_OFF  = 'd4;
  localparam logic [AW-2:0] REG_BDR  = 'd5;
  localparam logic [AW-2:0] REG_BDL  = 'd6;
  localparam logic [AW-2:0] REG_BPL  = 'd7;
  localparam logic [AW-2:0] REG_BPN  = 'd8;
  localparam logic [AW-2:0] REG_STS  = 'd9;
  localparam logic [AW-2:0] REG_CBPL = 'd10;
  localparam logic [AW-2:0] REG_CBPN = 'd11;

endpackage

`default_nettype wire

//--- src/asg_ptr_gen.sv
//////////////////////////////////////////////////
// asg pointer engine
// start/trigger status, periodic pointer and burst
// counters, table address with valid and last tags
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_ptr_gen (
  input  logic                     sto,
  input  logic                     ctl_rst,
  input  logic                     cmd_str,
  input  logic                     cmd_stp,
  input  logic                     cmd_trg,
  input  logic                     trg,
  input  logic                     adv,
  input  logic                     cfg_ben,
  input  logic                     cfg_inf,
  input  logic [asg_pkg::PW-1:0]   cfg_siz,
  input  logic [asg_pkg::PW-1:0]   cfg_ste,
  input  logic [asg_pkg::PW-1:0]   cfg_off,
  input  logic [asg_pkg::CWR-1:0]  cfg_bdr,
  input  logic [asg_pkg::CWM-1:0]  cfg_bdl,
  input  logic [asg_pkg::CWL-1:0]  cfg_bpl,
  input  logic [asg_pkg::CWN-1:0]  cfg_bpn,
  output logic                     sts_str,
  output logic                     sts_trg,
  output logic [asg_pkg::CWL-1:0]  sts_bpl,
  output logic [asg_pkg::CWN-1:0]  sts_bpn,
  output logic [asg_pkg::CWM-1:0]  raddr,
  output logic                     ren,
  output logic                     tag_vld,
  output logic                     tag_lst,
  output logic                     evn_per
);

  logic                     ctl_run;
  logic                     ctl_end;
  logic                     end_bst;
  logic                     step;
  logic [asg_pkg::PW-1:0]   ptr_cur;
  logic [asg_pkg::PW+1:0]   ptr_add;
  logic [asg_pkg::PW+1:0]   ptr_sub;
  logic [asg_pkg::CWR-1:0]  cnt_bdr;
  logic [asg_pkg::CWM-1:0]  cnt_bdl;
  logic                     cnt_idl;
  logic                     end_bdr;
  logic                     end_bdl;
  logic                     end_bpl;
  logic                     end_bpn;

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  // trigger while started, or together with start
  // ignored while already running
  assign ctl_run = (cmd_trg | trg) & (sts_str | cmd_str) & ~sts_trg & ~cmd_stp;
  // address beat consumed
  assign step    = sts_trg & adv;
  assign end_bst = cfg_ben & step & end_bpl & end_bpn;
  assign ctl_end = cmd_stp | end_bst;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_str <= 1'b0;
      sts_trg <= 1'b0;
      tag_vld <= 1'b0;
      evn_per <= 1'b0;
    end else begin
      if (cmd_stp) begin
        sts_str <= 1'b0;
      end else if (cmd_str) begin
        sts_str <= 1'b1;
      end
      if (ctl_end) begin
        sts_trg <= 1'b0;
      end else if (ctl_run) begin
        sts_trg <= 1'b1;
      end
      // address stage valid, next beat only while running
      if (ctl_run) begin
        tag_vld <= 1'b1;
      end else if (adv) begin
        tag_vld <= sts_trg & ~ctl_end;
      end
      evn_per <= cfg_ben & step & end_bpl;
    end
  end

  //////////////////////////////////////////////////
  // periodic pointer
  //////////////////////////////////////////////////

  // two guard bits, top one is the borrow
  assign ptr_add = {2'b00, ptr_cur} + {2'b00, cfg_ste} + 1'b1;
  assign ptr_sub = ptr_add - {2'b00, cfg_siz} - 1'b1;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (ctl_run) begin
      ptr_cur <= cfg_off;
    end else if (step && !cfg_ben) begin
      // wrap when past the table size
      ptr_cur <= ptr_sub[asg_pkg::PW+1] ? ptr_add[asg_pkg::PW-1:0]
                                        : ptr_sub[asg_pkg::PW-1:0];
    end
  end

  //////////////////////////////////////////////////
  // burst counters
  //////////////////////////////////////////////////

  assign end_bdr = (cnt_bdr == cfg_bdr);
  assign end_bdl = (cnt_bdl == cfg_bdl);
  assign end_bpl = (sts_bpl == cfg_bpl);
  assign end_bpn = (sts_bpn == cfg_bpn) & ~cfg_inf;

  always_ff @(posedge sto) begin
    if (ctl_rst || ctl_run) begin
      cnt_bdr <= '0;
      cnt_bdl <= '0;
      cnt_idl <= 1'b0;
      sts_bpl <= '0;
      sts_bpn <= '0;
    end else if (step && cfg_ben && !end_bst) begin
      if (end_bpl) begin
        // next period
        cnt_bdr <= '0;
        cnt_bdl <= '0;
        cnt_idl <= 1'b0;
        sts_bpl <= '0;
        sts_bpn <= sts_bpn + 1'b1;
      end else begin
        sts_bpl <= sts_bpl + 1'b1;
        // idle keeps the last address
        if (!cnt_idl) begin
          if (!end_bdr) begin
            cnt_bdr <= cnt_bdr + 1'b1;
          end else begin
            cnt_bdr <= '0;
            if (end_bdl) begin
              cnt_idl <= 1'b1;
            end else begin
              cnt_bdl <= cnt_bdl + 1'b1;
            end
          end
        end
      end
    end
  end

  // table address and tags
  assign raddr   = cfg_ben ? cnt_bdl : ptr_cur[asg_pkg::PW-1:asg_pkg::CWF];
  assign ren     = tag_vld;
  assign tag_lst = tag_vld & cfg_ben & end_bpl & end_bpn;

endmodule

`default_nettype wire

//--- src/asg_regs.sv
//////////////////////////////////////////////////
// asg host register block
// four-phase req/ack port, configuration, commands,
// table write path and status readback
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_regs (
  input  logic                        sto,
  input  logic                        ctl_rst,
  input  logic                        req,
  input  logic                        we,
  input  logic [asg_pkg::AW-1:0]      addr,
  input  logic [asg_pkg::HW-1:0]      wdata,
  output logic                        ack,
  output logic [asg_pkg::HW-1:0]      rdata,
  output logic                        tbl_we,
  output logic [asg_pkg::CWM-1:0]     tbl_waddr,
  output asg_pkg::smp_t               tbl_wdata,
  output logic                        cmd_str,
  output logic                        cmd_stp,
  output logic                        cmd_trg,
  output logic                        cfg_ben,
  output logic                        cfg_inf,
  output logic [asg_pkg::PW-1:0]      cfg_siz,
  output logic [asg_pkg::PW-1:0]      cfg_ste,
  output logic [asg_pkg::PW-1:0]      cfg_off,
  output logic [asg_pkg::CWR-1:0]     cfg_bdr,
  output logic [asg_pkg::CWM-1:0]     cfg_bdl,
  output logic [asg_pkg::CWL-1:0]     cfg_bpl,
  output logic [asg_pkg::CWN-1:0]     cfg_bpn,
  input  logic                        sts_str,
  input  logic                        sts_trg,
  input  logic [asg_pkg::CWL-1:0]     sts_bpl,
  input  logic [asg_pkg::CWN-1:0]     sts_bpn,
  input  asg_pkg::smp_t               tbl_rdata
);

  logic                    req_q;
  logic                    acc;
  logic                    tbl_sel;
  logic                    tbl_rd;
  logic                    tbl_pend;
  logic                    wr_reg;
  logic                    wr_ctl;
  logic [asg_pkg::AW-2:0]  reg_adr;
  logic [asg_pkg::HW-1:0]  rd_mux;

  // one access per rising req
  assign acc     = req & ~req_q;
  // top address bit picks the table
  assign tbl_sel = addr[asg_pkg::AW-1];
  assign reg_adr = addr[asg_pkg::AW-2:0];
  assign tbl_rd  = acc & ~we & tbl_sel;
  assign wr_reg  = acc & we & ~tbl_sel;
  assign wr_ctl  = wr_reg & (reg_adr == asg_pkg::REG_CTL);

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      req_q    <= 1'b0;
      tbl_pend <= 1'b0;
      ack      <= 1'b0;
    end else begin
      req_q    <= req;
      // table read data arrives one cycle late
      tbl_pend <= tbl_rd;
      if (tbl_pend || (acc && !tbl_rd)) begin
        ack <= 1'b1;
      end else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

  // readback, narrow fields zero-extended
  always_comb begin
    rd_mux = '0;
    if (tbl_pend) begin
      rd_mux[asg_pkg::DW-1:0] = tbl_rdata;
    end else begin
      case (reg_adr)
        asg_pkg::REG_MODE: rd_mux[1:0] = {cfg_inf, cfg_ben};
        asg_pkg::REG_SIZ:  rd_mux[asg_pkg::PW-1:0] = cfg_siz;
        asg_pkg::REG_STE:  rd_mux[asg_pkg::PW-1:0] = cfg_ste;
        asg_pkg::REG_OFF:  rd_mux[asg_pkg::PW-1:0] = cfg_off;
        asg_pkg::REG_BDR:  rd_mux[asg_pkg::CWR-1:0] = cfg_bdr;
        asg_pkg::REG_BDL:  rd_mux[asg_pkg::CWM-1:0] = cfg_bdl;
        asg_pkg::REG_BPL:  rd_mux[asg_pkg::CWL-1:0] = cfg_bpl;
        asg_pkg::REG_BPN:  rd_mux[asg_pkg::CWN-1:0] = cfg_bpn;
        asg_pkg::REG_STS:  rd_mux[1:0] = {sts_trg, sts_str};
        asg_pkg::REG_CBPL: rd_mux[asg_pkg::CWL-1:0] = sts_bpl;
        asg_pkg::REG_CBPN: rd_mux[asg_pkg::CWN-1:0] = sts_bpn;
        default:           rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge sto) begin
    if (tbl_pend || (acc && !we && !tbl_sel)) begin
      rdata <= rd_mux;
    end
  end

  //////////////////////////////////////////////////
  // table writes and commands
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    tbl_waddr <= addr[asg_pkg::CWM-1:0];
    tbl_wdata <= wdata[asg_pkg::DW-1:0];
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      tbl_we  <= 1'b0;
      cmd_str <= 1'b0;
      cmd_stp <= 1'b0;
      cmd_trg <= 1'b0;
    end else begin
      tbl_we  <= acc & we & tbl_sel;
      // single cycle pulses
      cmd_str <= wr_ctl & wdata[0];
      cmd_stp <= wr_ctl & wdata[1];
      cmd_trg <= wr_ctl & wdata[2];
    end
  end

  // configuration
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_siz <= '0;
      cfg_ste <= '0;
      cfg_off <= '0;
      cfg_bdr <= '0;
      cfg_bdl <= '0;
      cfg_bpl <= '0;
      cfg_bpn <= '0;
    end else if (wr_reg) begin
      case (reg_adr)
        asg_pkg::REG_MODE: begin
          cfg_ben <= wdata[0];
          cfg_inf <= wdata[1];
        end
        asg_pkg::REG_SIZ: cfg_siz <= wdata[asg_pkg::PW-1:0];
        asg_pkg::REG_STE: cfg_ste <= wdata[asg_pkg::PW-1:0];
        asg_pkg::REG_OFF: cfg_off <= wdata[asg_pkg::PW-1:0];
        asg_pkg::REG_BDR: cfg_bdr <= wdata[asg_pkg::CWR-1:0];
        asg_pkg::REG_BDL: cfg_bdl <= wdata[asg_pkg::CWM-1:0];
        asg_pkg::REG_BPL: cfg_bpl <= wdata[asg_pkg::CWL-1:0];
        asg_pkg::REG_BPN: cfg_bpn <= wdata[asg_pkg::CWN-1:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/asg_table.sv
//////////////////////////////////////////////////
// asg sample table
// host write/read port and registered stream read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module asg_table (
  input  logic                     sto,
  input  logic                     we,
  input  logic [asg_pkg::CWM-1:0]  waddr,
  input  asg_pkg::smp_t            wdata,
  input  logic [asg_pkg::CWM-1:0]  haddr,
  input  logic                     ren,
  input  logic [asg_pkg::CWM-1:0]  raddr,
  input  logic                     adv,
  output asg_pkg::smp_t            hdata,
  output asg_pkg::smp_t            rdata
);

  asg_pkg::smp_t mem [0:2**asg_pkg::CWM-1];

  // host side, read registered every cycle
  always_ff @(posedge sto) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    hdata <= mem[haddr];
  end

  // stream side
  // holds its word while the pipeline stalls
  always_ff @(posedge sto) begin
    if (ren && adv) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire
